// File: common/adder_pkg.sv
package adder_pkg;

  // operand width of the adder.
  localparam int DATA_W = 64;

  // propagate/generate width, position 0 holds the carry-in.
  localparam int PG_W = DATA_W + 1;

  // number of kogge-stone levels, spans 1 through 32.
  localparam int PREFIX_LEVELS = 6;

  // bitwise or group propagate/generate pair.
  typedef struct packed {
    logic [PG_W-1:0] p;  // propagate.
    logic [PG_W-1:0] g;  // generate.
  } pg_t;

endpackage

// File: common/exu_pkg.sv
package exu_pkg;

  // operations the unit supports.
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,  // a + b.
    OP_SUB = 2'd1,  // a + ~b + 1.
    OP_ADC = 2'd2   // a + b + cin.
  } op_t;

  localparam int TAG_W = 4;

  // request from the upstream sender.
  typedef struct packed {
    op_t                          op;
    logic [adder_pkg::DATA_W-1:0] a;
    logic [adder_pkg::DATA_W-1:0] b;
    logic                         cin;  // only used by OP_ADC.
    logic [TAG_W-1:0]             tag;
  } req_t;

  // arithmetic flags of one result.
  typedef struct packed {
    logic carry;
    logic overflow;  // signed overflow.
    logic zero;
    logic negative;
  } flags_t;

  // tagged result to the downstream receiver.
  typedef struct packed {
    logic [TAG_W-1:0]             tag;
    logic [adder_pkg::DATA_W-1:0] sum;
    flags_t                       flags;
  } rsp_t;

  // result fifo depth, also the sender's initial credits.
  localparam int QUEUE_DEPTH = 8;
  localparam int DN_CREDITS  = 4;   // credits toward the receiver after reset.
  localparam int CNT_W       = 4;   // holds 0 to QUEUE_DEPTH.

endpackage

// File: ks_adder/ks_prefix_tree.sv
`timescale 1ns/10ps

module ks_prefix_tree (
  input  adder_pkg::pg_t pg_in,
  output adder_pkg::pg_t pg_out
);

  // one pg pair per level, lvl[0] is the bitwise input.
  adder_pkg::pg_t lvl [adder_pkg::PREFIX_LEVELS+1];

  assign lvl[0] = pg_in;

  // level l combines each position with the one (1 << l) below it.
  for (genvar l = 0; l < adder_pkg::PREFIX_LEVELS; l++) begin : g_level
    for (genvar i = 0; i < adder_pkg::PG_W; i++) begin : g_bit
      if (i >= (1 << l)) begin : g_comb
        // ao21 step.
        assign lvl[l+1].g[i] = lvl[l].g[i] | (lvl[l].p[i] & lvl[l].g[i-(1<<l)]);
        assign lvl[l+1].p[i] = lvl[l].p[i] & lvl[l].p[i-(1<<l)];
      end else begin : g_pass
        // nothing below to combine with.
        assign lvl[l+1].g[i] = lvl[l].g[i];
        assign lvl[l+1].p[i] = lvl[l].p[i];
      end
    end
  end

  // after six levels every position up to 63 reaches down to cin.
  assign pg_out = lvl[adder_pkg::PREFIX_LEVELS];

endmodule

// File: ks_adder/ks_adder.sv
`timescale 1ns/10ps

module ks_adder (
  input  logic [adder_pkg::DATA_W-1:0] a,
  input  logic [adder_pkg::DATA_W-1:0] b,
  input  logic                         cin,
  output logic [adder_pkg::DATA_W-1:0] sum,
  output logic                         cout
);

  adder_pkg::pg_t pg;   // bitwise pairs, cin at position 0.
  adder_pkg::pg_t grp;  // group pairs from the tree.

  // position 0 generates the carry-in and never propagates.
  assign pg.p = {a ^ b, 1'b0};
  assign pg.g = {a & b, cin};

  ks_prefix_tree u_tree (
    .pg_in  (pg),
    .pg_out (grp)
  );

  // carry into bit k is the group generate at pg position k.
  assign sum = pg.p[adder_pkg::PG_W-1:1] ^ grp.g[adder_pkg::PG_W-2:0];

  assign cout = pg.g[adder_pkg::PG_W-1] |
                (pg.p[adder_pkg::PG_W-1] & grp.g[adder_pkg::PG_W-2]);

endmodule

// File: verilog/add_pipe.sv
`timescale 1ns/10ps

module add_pipe (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req_valid,
  input  exu_pkg::req_t req,
  output logic          res_valid,
  output exu_pkg::rsp_t res
);

  // conditioned operands held between the two stages.
  typedef struct packed {
    logic [adder_pkg::DATA_W-1:0] a;
    logic [adder_pkg::DATA_W-1:0] b;
    logic                         cin;
    logic [exu_pkg::TAG_W-1:0]    tag;
  } stage_t;

  stage_t                       s1_nxt;
  stage_t                       s1;
  logic                         s1_valid;
  logic [adder_pkg::DATA_W-1:0] sum;
  logic                         cout;
  exu_pkg::flags_t              flags;

  // operand conditioning.
  always_comb begin
    s1_nxt.a   = req.a;
    s1_nxt.b   = req.b;
    s1_nxt.cin = 1'b0;
    s1_nxt.tag = req.tag;
    case (req.op)
      exu_pkg::OP_SUB: begin
        s1_nxt.b   = ~req.b;  // two's complement of b.
        s1_nxt.cin = 1'b1;
      end
      exu_pkg::OP_ADC: s1_nxt.cin = req.cin;
      default:         s1_nxt.cin = 1'b0;
    endcase
  end

  // stage 1.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) s1 <= s1_nxt;
  end

  ks_adder u_adder (
    .a    (s1.a),
    .b    (s1.b),
    .cin  (s1.cin),
    .sum  (sum),
    .cout (cout)
  );

  // same input signs with a different result sign means signed overflow.
  assign flags.carry    = cout;
  assign flags.overflow = (s1.a[adder_pkg::DATA_W-1] == s1.b[adder_pkg::DATA_W-1]) &&
                          (sum[adder_pkg::DATA_W-1] != s1.a[adder_pkg::DATA_W-1]);
  assign flags.zero     = (sum == '0);
  assign flags.negative = sum[adder_pkg::DATA_W-1];

  // stage 2.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res.tag   <= s1.tag;
      res.sum   <= sum;
      res.flags <= flags;
    end
  end

endmodule

// File: verilog/result_queue.sv
`timescale 1ns/10ps

module result_queue (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          res_valid,
  input  exu_pkg::rsp_t res,
  output logic          rsp_valid,
  output exu_pkg::rsp_t rsp,
  input  logic          dn_credit,
  output logic          up_credit
);

  exu_pkg::rsp_t mem [exu_pkg::QUEUE_DEPTH];

  logic [$clog2(exu_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(exu_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
  logic [exu_pkg::CNT_W-1:0]               count;    // entries held.
  logic [exu_pkg::CNT_W-1:0]               credits;  // downstream credits.
  logic                                    send;

  // a send needs an entry and a downstream credit.
  assign send = (count != '0) && (credits != '0);

  // store each result at the write pointer.
  always_ff @(posedge clk) begin
    if (res_valid) mem[wr_ptr] <= res;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (res_valid) wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth.
      if (send)      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // occupancy.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({res_valid, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both.
      endcase
    end
  end

  // downstream credit counter.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= exu_pkg::CNT_W'(exu_pkg::DN_CREDITS);
    end else begin
      case ({dn_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= send;
    end
  end

  // head entry onto the output.
  always_ff @(posedge clk) begin
    if (send) rsp <= mem[rd_ptr];
  end

  // each response that leaves frees one upstream slot.
  assign up_credit = rsp_valid;

endmodule

// File: verilog/add_exu_top.sv
`timescale 1ns/10ps

module add_exu_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req_valid,
  input  exu_pkg::req_t req,
  output logic          up_credit,
  output logic          rsp_valid,
  output exu_pkg::rsp_t rsp,
  input  logic          dn_credit
);

  // pipeline to queue, no back-pressure on this path.
  logic          res_valid;
  exu_pkg::rsp_t res;

  // two-stage add and flags.
  add_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .res_valid (res_valid),
    .res       (res)
  );

  // result fifo with both credit interfaces.
  result_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res       (res),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .dn_credit (dn_credit),
    .up_credit (up_credit)
  );

endmodule

// File: tests/add_exu_tb.sv
`timescale 1ns/10ps

module add_exu_tb;

  localparam int N_ROWS     = 16;
  localparam int N_RANDOM   = 200;
  localparam int N_HOLD     = 8;   // requests sent while dn_credit is withheld.
  localparam int MSB        = adder_pkg::DATA_W - 1;
  localparam int TIMEOUT_NS = (N_ROWS + N_RANDOM) * 30 * 8;

  localparam exu_pkg::op_t ADD = exu_pkg::OP_ADD;
  localparam exu_pkg::op_t SUB = exu_pkg::OP_SUB;
  localparam exu_pkg::op_t ADC = exu_pkg::OP_ADC;

  // one directed row, expected values worked out by hand.
  typedef struct packed {
    exu_pkg::op_t    op;
    logic [MSB:0]    a;
    logic [MSB:0]    b;
    logic            cin;
    logic [MSB:0]    sum;
    exu_pkg::flags_t flags;
  } vec_t;

  logic          clk;
  logic          rst_n;
  logic          req_valid;
  exu_pkg::req_t req;
  logic          up_credit;
  logic          rsp_valid;
  exu_pkg::rsp_t rsp;
  logic          dn_credit;

  vec_t          tbl [$];
  exu_pkg::req_t pend_req [$];  // waiting for an upstream credit.
  exu_pkg::rsp_t pend_exp [$];
  exu_pkg::rsp_t exp_q [$];     // sent, response still due.
  int            due_q [$];     // cycle at which each dn_credit goes back.
  int            delay_q [$];

  logic [exu_pkg::TAG_W-1:0] next_tag = '0;
  int cycle      = 0;
  int credits    = exu_pkg::QUEUE_DEPTH;  // sender side credit count.
  int pushed     = 0;
  int sent_total = 0;
  int rsp_total  = 0;
  int up_total   = 0;
  int errors     = 0;
  bit hold_dn    = 1'b0;

  add_exu_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .up_credit (up_credit),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .dn_credit (dn_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns, %0d of %0d responses seen",
             TIMEOUT_NS, rsp_total, pushed);
    $display("Test failed");
    $finish;
  end

  task automatic check_flags(input exu_pkg::flags_t got, input exu_pkg::flags_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: rsp.flags got %b exp %b", $time, got, exp);
    end
  endtask

  task automatic check_rsp(input exu_pkg::rsp_t got, input exu_pkg::rsp_t exp);
    if (got.tag !== exp.tag) begin
      errors++;
      $display("** Error at %0t: rsp.tag got %h exp %h", $time, got.tag, exp.tag);
    end
    if (got.sum !== exp.sum) begin
      errors++;
      $display("** Error at %0t: rsp.sum got %h exp %h", $time, got.sum, exp.sum);
    end
    check_flags(got.flags, exp.flags);
  endtask

  task automatic check_cnt(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  // 65-bit reference add with the flag rules.
  function automatic exu_pkg::rsp_t model_rsp(input exu_pkg::req_t r);
    logic [MSB:0]   bb;
    logic           c;
    logic [MSB+1:0] wide;
    exu_pkg::rsp_t  m;
    bb = (r.op == exu_pkg::OP_SUB) ? ~r.b : r.b;
    c  = (r.op == exu_pkg::OP_SUB) ? 1'b1 : (r.op == exu_pkg::OP_ADC) ? r.cin : 1'b0;
    wide = {1'b0, r.a} + {1'b0, bb} + {{adder_pkg::DATA_W{1'b0}}, c};
    m.tag            = r.tag;
    m.sum            = wide[MSB:0];
    m.flags.carry    = wide[MSB+1];
    m.flags.overflow = (r.a[MSB] == bb[MSB]) && (m.sum[MSB] != r.a[MSB]);
    m.flags.zero     = (m.sum == '0);
    m.flags.negative = m.sum[MSB];
    return m;
  endfunction

  task automatic add_row(input exu_pkg::op_t op, input logic [MSB:0] a,
                         input logic [MSB:0] b, input logic cin,
                         input logic [MSB:0] sum, input exu_pkg::flags_t flags);
    tbl.push_back('{op, a, b, cin, sum, flags});
  endtask

  // flags are {carry, overflow, zero, negative}.
  task automatic fill_table;
    add_row(ADD, 64'hffff_ffff_ffff_ffff, 64'h1, 1'b0,
            64'h0, 4'b1010);  // all ones plus one.
    add_row(SUB, 64'h8000_0000_0000_0000, 64'h1, 1'b0,
            64'h7fff_ffff_ffff_ffff, 4'b1100);  // most negative minus one.
    add_row(SUB, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 1'b0,
            64'h0, 4'b1010);
    add_row(ADD, 64'h0, 64'h0, 1'b0,
            64'h0, 4'b0010);
    add_row(ADC, 64'h1, 64'h1, 1'b1,
            64'h3, 4'b0000);
    // carry-in ripples through all 64 bits.
    add_row(ADC, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1,
            64'h0, 4'b1010);
    add_row(ADD, 64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555, 1'b0,
            64'hffff_ffff_ffff_ffff, 4'b0001);
    add_row(ADD, 64'haaaa_aaaa_aaaa_aaaa, 64'haaaa_aaaa_aaaa_aaaa, 1'b0,
            64'h5555_5555_5555_5554, 4'b1100);
    add_row(ADD, 64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555, 1'b0,
            64'haaaa_aaaa_aaaa_aaaa, 4'b0101);
    add_row(SUB, 64'h5555_5555_5555_5555, 64'haaaa_aaaa_aaaa_aaaa, 1'b0,
            64'haaaa_aaaa_aaaa_aaab, 4'b0101);
    add_row(ADD, 64'h7fff_ffff_ffff_ffff, 64'h1, 1'b0,
            64'h8000_0000_0000_0000, 4'b0101);
    add_row(ADD, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0,
            64'h0, 4'b1110);
    add_row(SUB, 64'h0, 64'h1, 1'b0,
            64'hffff_ffff_ffff_ffff, 4'b0001);
    add_row(ADC, 64'h7fff_ffff_ffff_ffff, 64'h0, 1'b1,
            64'h8000_0000_0000_0000, 4'b0101);
    add_row(ADD, 64'h0000_0000_ffff_ffff, 64'h1, 1'b0,
            64'h0000_0001_0000_0000, 4'b0000);
    add_row(ADD, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0,
            64'hffff_ffff_ffff_fffe, 4'b1001);
  endtask

  task automatic random_req(output exu_pkg::req_t r);
    r.op  = exu_pkg::op_t'(2'($urandom_range(2)));
    r.a   = {$urandom, $urandom};
    r.b   = {$urandom, $urandom};
    r.cin = 1'($urandom_range(1));
    r.tag = '0;
  endtask

  // tags go out in sequence.
  task automatic queue_request(input exu_pkg::req_t r, input exu_pkg::rsp_t e);
    r.tag = next_tag;
    e.tag = next_tag;
    next_tag++;
    pend_req.push_back(r);
    pend_exp.push_back(e);
    pushed++;
  endtask

  task automatic wait_drain;
    while (rsp_total != pushed || due_q.size() != 0) @(negedge clk);
  endtask

  // sender, receiver and response checker.
  always @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      dn_credit <= 1'b0;
    end else begin
      cycle++;
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected response at %0t with no request outstanding", $time);
        end else begin
          check_rsp(rsp, exp_q.pop_front());
        end
        due_q.push_back(cycle + delay_q[rsp_total % delay_q.size()]);
        rsp_total++;
      end
      if (up_credit) begin
        up_total++;
        credits++;
        if (up_total > sent_total) begin
          errors++;
          $display("up_credit pulse at %0t exceeds the %0d requests sent", $time, sent_total);
        end
      end
      // at most one credit back per cycle, once its delay has passed.
      if (!hold_dn && due_q.size() != 0 && due_q[0] <= cycle) begin
        dn_credit <= 1'b1;
        void'(due_q.pop_front());
      end else begin
        dn_credit <= 1'b0;
      end
      if (pend_req.size() != 0 && credits > 0) begin
        req_valid <= 1'b1;
        req       <= pend_req.pop_front();
        exp_q.push_back(pend_exp.pop_front());
        credits--;
        sent_total++;
      end else begin
        req_valid <= 1'b0;
      end
    end
  end

  initial begin
    exu_pkg::req_t r;
    exu_pkg::rsp_t e;
    int            hold_base;
    void'($urandom(32'hb023));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    dn_credit = 1'b0;
    repeat (N_ROWS + N_RANDOM + N_HOLD) delay_q.push_back(int'($urandom_range(5)));
    fill_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // nothing may leave an idle unit.
    repeat (8) @(negedge clk);
    check_cnt("rsp_valid pulses while idle", rsp_total, 0);
    check_cnt("up_credit pulses while idle", up_total, 0);

    foreach (tbl[i]) begin
      r.op   = tbl[i].op;
      r.a    = tbl[i].a;
      r.b    = tbl[i].b;
      r.cin  = tbl[i].cin;
      r.tag  = '0;
      e.sum  = tbl[i].sum;
      e.flags = tbl[i].flags;
      e.tag  = '0;
      queue_request(r, e);
    end
    wait_drain();

    repeat (N_RANDOM) begin
      random_req(r);
      queue_request(r, model_rsp(r));
    end
    wait_drain();

    // receiver stalls, only the credits already held may be spent.
    hold_dn   = 1'b1;
    hold_base = rsp_total;
    repeat (N_HOLD) begin
      random_req(r);
      queue_request(r, model_rsp(r));
    end
    while (rsp_total - hold_base < exu_pkg::DN_CREDITS) @(negedge clk);
    repeat (20) @(negedge clk);
    check_cnt("responses while dn_credit withheld", rsp_total - hold_base,
              exu_pkg::DN_CREDITS);
    hold_dn = 1'b0;
    wait_drain();

    check_cnt("up_credit total", up_total, sent_total);
    check_cnt("requests sent", sent_total, pushed);
    check_cnt("sender credits", credits, exu_pkg::QUEUE_DEPTH);
    $display("requests %0d, responses %0d, errors %0d", sent_total, rsp_total, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/adder_pkg.sv
common/exu_pkg.sv
ks_adder/ks_prefix_tree.sv
ks_adder/ks_adder.sv
verilog/add_pipe.sv
verilog/result_queue.sv
verilog/add_exu_top.sv
tests/add_exu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module add_exu_tb \
  -f verilog.f \
  -o add_exu_sim

./obj_dir/add_exu_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
